// File: Bender.yml
package:
  name: rhythm_game

sources:
  - include_dirs:
      - logic
    files:
      - logic/kbd_pkg.sv
      - logic/game_pkg.sv
      - logic/key_tracker.sv
      - logic/note_sequencer.sv
      - logic/note_painter.sv
      - logic/lane_scorer.sv
      - logic/seg_decoder.sv
      - logic/rhythm_top.sv
  - target: simulation
    include_dirs:
      - logic
    files:
      - bench/rhythm_tb.sv

// File: bench/rhythm_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "game_defs.svh"

module rhythm_tb;

  localparam int round_cycles = 517; // Load, draw, hold and erase at speed 1
  localparam int notes_played = 9;
  localparam int max_cycles   = notes_played * 120 * round_cycles + 20000;

  // How the keys are played at the hit row
  localparam int play_hit           = 0;
  localparam int play_wrong         = 1;
  localparam int play_ext_release   = 2;
  localparam int play_space_release = 3;

  logic             clk;
  logic             reset;
  logic [7:0]       scan_byte;
  logic             scan_valid;
  logic             start;
  logic [1:0]       speed;
  logic             plot;
  game_pkg::pixel_t pixel;
  logic [6:0]       hex0;
  logic [6:0]       hex1;

  int         errors = 0;
  int         checks = 0;
  int         cycles = 0;
  int         exp_y;     // Row of the next draw
  int         exp_total; // Score as a plain number
  int         exp_bonus;
  logic [7:0] note_x;    // Left edge of the current note

  rhythm_top i_rhythm_top (
    .clk        (clk),
    .reset      (reset),
    .scan_byte  (scan_byte),
    .scan_valid (scan_valid),
    .start      (start),
    .speed      (speed),
    .plot       (plot),
    .pixel      (pixel),
    .hex0       (hex0),
    .hex1       (hex1)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  initial begin
    while (cycles < max_cycles) begin
      @(posedge clk);
      cycles = cycles + 1;
    end
    $display("Run stopped after %0d cycles before the tests finished", cycles);
    $display("Checks: %0d, errors: %0d", checks, errors);
    $display("TESTBENCH FAILED");
    $finish;
  end

  task automatic next_cycle();
    @(posedge clk);
    #10;
  endtask

  function automatic logic [3:0] seg_to_digit(input logic [6:0] seg);
    logic [6:0] lit;
    lit = ~seg; // Lit segments from g down to a
    case (lit)
      7'b0111111: return 4'd0;
      7'b0000110: return 4'd1;
      7'b1011011: return 4'd2;
      7'b1001111: return 4'd3;
      7'b1100110: return 4'd4;
      7'b1101101: return 4'd5;
      7'b1111101: return 4'd6;
      7'b0000111: return 4'd7;
      7'b1111111: return 4'd8;
      7'b1101111: return 4'd9;
      default:    return 4'hF;
    endcase
  endfunction

  function automatic game_pkg::score_t digits_of(input int total);
    game_pkg::score_t s;
    s.tens  = 4'(total / 10);
    s.units = 4'(total % 10);
    return s;
  endfunction

  function automatic logic [7:0] lane_key_code(input logic [7:0] x);
    case (x)
      `LANE0_X: return `CODE_W;
      `LANE1_X: return `CODE_A;
      `LANE2_X: return `CODE_S;
      `LANE3_X: return `CODE_D;
      default:  return 8'h00;
    endcase
  endfunction

  function automatic logic [7:0] other_key_code(input logic [7:0] code);
    case (code)
      `CODE_W: return `CODE_A;
      `CODE_A: return `CODE_S;
      `CODE_S: return `CODE_D;
      default: return `CODE_W;
    endcase
  endfunction

  task automatic compare_pixel(input string name, input game_pkg::pixel_t want,
                               input game_pkg::pixel_t got);
    checks++;
    if (got !== want) begin
      errors++;
      $display("mismatch %s: expected (%0d,%0d) colour %0d, actual (%0d,%0d) colour %0d",
               name, want.x, want.y, want.colour, got.x, got.y, got.colour);
    end
  endtask

  task automatic compare_score(input string name, input game_pkg::score_t want);
    game_pkg::score_t got;
    got.tens  = seg_to_digit(hex1);
    got.units = seg_to_digit(hex0);
    checks++;
    if (got !== want) begin
      errors++;
      $display("mismatch %s: expected score %0d%0d, actual %0h%0h",
               name, want.tens, want.units, got.tens, got.units);
    end
  endtask

  task automatic compare_count(input string name, input int want, input int got);
    checks++;
    if (got != want) begin
      errors++;
      $display("mismatch %s: expected %0d cycles, actual %0d", name, want, got);
    end
  endtask

  task automatic send_byte(input logic [7:0] code);
    scan_byte  = code;
    scan_valid = 1'b1;
    next_cycle();
    scan_valid = 1'b0;
  endtask

  // Counts plot-low cycles up to the next plotted pixel
  task automatic count_low(input string name, output int low);
    low = 0;
    next_cycle();
    while (plot !== 1'b1 && low < 1000) begin
      low++;
      next_cycle();
    end
    if (low == 1000) begin
      errors++;
      $display("%s: plot stayed low for 1000 cycles", name);
    end
  endtask

  task automatic paint_block(input string name, input logic [2:0] colour);
    int               high;
    int               i;
    game_pkg::pixel_t want;
    high = 0;
    for (i = 0; i < 256; i++) begin
      if (i > 0) begin
        next_cycle();
      end
      want.x      = note_x + 8'(i / 8); // Row runs fastest
      want.y      = 7'(exp_y + i % 8);
      want.colour = colour;
      if (plot === 1'b1) begin
        high++;
      end
      compare_pixel(name, want, pixel);
    end
    compare_count({name, " plot"}, 256, high);
  endtask

  task automatic run_round(input string name);
    int low;
    count_low(name, low);
    compare_count({name, " load gap"}, 1, low);
    if (exp_y == 0) begin
      note_x = pixel.x; // Respawned note takes its lane from the first pixel
    end
    if (lane_key_code(note_x) == 8'h00) begin
      errors++;
      $display("%s: note x %0d is not the left edge of any lane", name, note_x);
    end
    paint_block({name, " draw"}, 3'd7);
    count_low(name, low);
    compare_count({name, " hold"}, 4, low);
    paint_block({name, " erase"}, 3'd0);
    exp_y = (exp_y == `HIT_ROW) ? 0 : exp_y + 1;
  endtask

  task automatic release_keys();
    send_byte(`CODE_BREAK);
    send_byte(`CODE_W);
    send_byte(`CODE_BREAK);
    send_byte(`CODE_A);
    send_byte(`CODE_BREAK);
    send_byte(`CODE_S);
    send_byte(`CODE_BREAK);
    send_byte(`CODE_D);
    send_byte(`CODE_BREAK);
    send_byte(`CODE_SPACE);
  endtask

  task automatic play_keys(input int mode, input logic [7:0] own_code);
    release_keys();
    case (mode)
      play_wrong: send_byte(other_key_code(own_code));
      default:    send_byte(own_code);
    endcase
    send_byte(`CODE_SPACE);
    if (mode == play_ext_release) begin
      send_byte(`CODE_EXT);
      send_byte(`CODE_BREAK);
      send_byte(own_code);
    end else if (mode == play_space_release) begin
      send_byte(`CODE_BREAK);
      send_byte(`CODE_SPACE);
    end
  endtask

  // Plays one note down to the hit row and checks the score after judging
  task automatic judge_note(input string name, input int mode);
    logic [7:0] own_code;
    while (exp_y != `HIT_ROW) begin
      run_round(name);
    end
    own_code = lane_key_code(note_x);
    fork
      run_round(name);
      play_keys(mode, own_code);
    join
    case (mode)
      play_hit: begin
        exp_total = (exp_total + exp_bonus) % 100;
        exp_bonus = (exp_bonus * 2 > `BONUS_MAX) ? `BONUS_MAX : exp_bonus * 2;
      end
      play_wrong: exp_bonus = 1;
      default: ; // Neither hit nor miss
    endcase
    run_round(name); // Score settles on the load that starts this round
    compare_score(name, digits_of(exp_total));
  endtask

  task automatic idle_quiet();
    int high;
    high = 0;
    repeat (100) begin
      next_cycle();
      if (plot === 1'b1) begin
        high++;
      end
    end
    compare_count("idle plot", 0, high);
    compare_score("idle", digits_of(0));
  endtask

  task automatic first_round();
    start = 1'b1;
    run_round("first_round");
  endtask

  task automatic bonus_hits();
    repeat (4) judge_note("bonus_hits", play_hit);
  endtask

  task automatic wrong_key_miss();
    judge_note("wrong_key", play_wrong);
    judge_note("wrong_key_next_hit", play_hit);
  endtask

  task automatic break_releases();
    judge_note("ext_break", play_ext_release);
    judge_note("space_break", play_space_release);
    judge_note("break_next_hit", play_hit);
  endtask

  initial begin
    reset      = 1'b0;
    scan_byte  = 8'h00;
    scan_valid = 1'b0;
    start      = 1'b0;
    speed      = 2'd1;
    exp_y      = 1; // First load moves the note down one row
    exp_total  = 0;
    exp_bonus  = 1;
    note_x     = `LANE0_X;
    repeat (4) @(posedge clk);
    #10;
    reset = 1'b1;
    idle_quiet();
    first_round();
    bonus_hits();
    wrong_key_miss();
    break_releases();
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: filelist.f
+incdir+logic
logic/kbd_pkg.sv
logic/game_pkg.sv
logic/key_tracker.sv
logic/note_sequencer.sv
logic/note_painter.sv
logic/lane_scorer.sv
logic/seg_decoder.sv
logic/rhythm_top.sv
bench/rhythm_tb.sv

// File: logic/game_defs.svh
`ifndef GAME_DEFS_SVH
`define GAME_DEFS_SVH

// Pixel field widths on the 160 by 120 display
`define X_W      8
`define Y_W      7
`define COLOUR_W 3

// Left edge of each lane
`define LANE0_X 4
`define LANE1_X 44
`define LANE2_X 84
`define LANE3_X 124

`define HIT_ROW   112 // Row where a note is judged
`define BONUS_MAX 8

// Hold counts picked by the speed switch
`define DELAY_0 840000
`define DELAY_1 3
`define DELAY_2 2360000
`define DELAY_3 4720000
`define DELAY_W 23 // Wide enough for the slowest hold count

// Keyboard make codes
`define CODE_W     8'h1D
`define CODE_A     8'h1C
`define CODE_S     8'h1B
`define CODE_D     8'h23
`define CODE_SPACE 8'h29

// Prefix bytes
`define CODE_BREAK 8'hF0
`define CODE_EXT   8'hE0

`endif

// File: logic/game_pkg.sv
`default_nettype none

`include "game_defs.svh"

package game_pkg;

  typedef struct packed {
    logic [`X_W-1:0]      x;
    logic [`Y_W-1:0]      y;
    logic [`COLOUR_W-1:0] colour;
  } pixel_t;

  // Encodings match the LFSR low bits
  typedef enum logic [1:0] {
    lane_d = 2'b00,
    lane_a = 2'b01,
    lane_s = 2'b10,
    lane_w = 2'b11
  } lane_t;

  // Top-left corner of the falling block
  typedef struct packed {
    logic [`X_W-1:0] x;
    logic [`Y_W-1:0] y;
  } note_pos_t;

  typedef struct packed {
    logic [3:0] tens;
    logic [3:0] units;
  } score_t;

  typedef enum logic [2:0] {
    seq_idle,
    seq_load,
    seq_draw,
    seq_hold,
    seq_erase
  } seq_state_t;

  // Row runs fastest in the block counter so the walk is column-major
  typedef union packed {
    logic [7:0] raw;
    struct packed {
      logic [4:0] col;
      logic [2:0] row;
    } pos;
  } block_step_u;

endpackage

`default_nettype wire

// File: logic/kbd_pkg.sv
`default_nettype none

package kbd_pkg;

  // Held level of each game key
  typedef struct packed {
    logic w;
    logic a;
    logic s;
    logic d;
    logic space;
  } key_set_t;

  // What kind of byte the decoder expects next
  typedef enum logic [1:0] {
    scan_make      = 2'b00,
    scan_break     = 2'b01,
    scan_ext_make  = 2'b10,
    scan_ext_break = 2'b11
  } scan_state_t;

endpackage

`default_nettype wire

// File: logic/key_tracker.sv
`timescale 1ns/1ps
`default_nettype none

`include "game_defs.svh"

module key_tracker (
  input  wire logic              clk,
  input  wire logic              reset,
  input  wire logic [7:0]        scan_byte,
  input  wire logic              scan_valid,
  output kbd_pkg::key_set_t      keys
);

  kbd_pkg::scan_state_t state;
  logic                 is_make; // Current byte is a press, not a release

  assign is_make = (state == kbd_pkg::scan_make);

  always_ff @(posedge clk) begin
    if (!reset) begin
      state <= kbd_pkg::scan_make;
      keys  <= '0;
    end else if (scan_valid) begin
      case (scan_byte)
        `CODE_EXT: state <= kbd_pkg::scan_ext_make;
        `CODE_BREAK: begin
          // Release after the extended prefix stays extended
          state <= is_make ? kbd_pkg::scan_break : kbd_pkg::scan_ext_break;
        end
        `CODE_W: begin
          keys.w <= is_make;
          state  <= kbd_pkg::scan_make;
        end
        `CODE_A: begin
          keys.a <= is_make;
          state  <= kbd_pkg::scan_make;
        end
        `CODE_S: begin
          keys.s <= is_make;
          state  <= kbd_pkg::scan_make;
        end
        `CODE_D: begin
          keys.d <= is_make;
          state  <= kbd_pkg::scan_make;
        end
        `CODE_SPACE: begin
          keys.space <= is_make;
          state      <= kbd_pkg::scan_make;
        end
        default: state <= kbd_pkg::scan_make; // Unused key ends its sequence
      endcase
    end
  end

  a_byte_known: assert property (
    @(posedge clk) disable iff (!reset) scan_valid |-> !$isunknown(scan_byte)
  );

endmodule

`default_nettype wire

// File: logic/lane_scorer.sv
`timescale 1ns/1ps
`default_nettype none

`include "game_defs.svh"

module lane_scorer (
  input  wire logic              clk,
  input  wire logic              reset,
  input  wire logic              step,
  input  wire kbd_pkg::key_set_t keys,
  output game_pkg::note_pos_t    note,
  output game_pkg::score_t       score
);

  logic [3:0]          lfsr;
  logic                feedback;
  game_pkg::lane_t     cur_lane;
  game_pkg::lane_t     spawn_lane;
  logic [3:0]          bonus;
  logic [4:0]          unit_sum;
  logic                own_key;
  logic                any_key;
  logic                hit;
  logic                miss;

  function automatic logic [`X_W-1:0] lane_left(input game_pkg::lane_t lane);
    case (lane)
      game_pkg::lane_w: lane_left = `X_W'(`LANE0_X);
      game_pkg::lane_a: lane_left = `X_W'(`LANE1_X);
      game_pkg::lane_s: lane_left = `X_W'(`LANE2_X);
      default:          lane_left = `X_W'(`LANE3_X);
    endcase
  endfunction

  assign feedback   = ~(lfsr[3] ^ lfsr[2]);
  assign spawn_lane = game_pkg::lane_t'(lfsr[1:0]);

  always_comb begin
    case (cur_lane)
      game_pkg::lane_w: own_key = keys.w;
      game_pkg::lane_a: own_key = keys.a;
      game_pkg::lane_s: own_key = keys.s;
      default:          own_key = keys.d;
    endcase
  end

  assign any_key  = keys.w || keys.a || keys.s || keys.d;
  assign hit      = keys.space && own_key;
  assign miss     = keys.space && !own_key && any_key; // Wrong lane pressed
  assign unit_sum = {1'b0, score.units} + {1'b0, bonus};

  always_ff @(posedge clk) begin
    if (!reset) begin
      lfsr     <= '0;
      cur_lane <= game_pkg::lane_w;
      note.x   <= `X_W'(`LANE0_X);
      note.y   <= '0;
      score    <= '0;
      bonus    <= 4'd1;
    end else begin
      lfsr <= {lfsr[2:0], feedback}; // Free running and sampled at respawn
      if (step) begin
        if (note.y != `Y_W'(`HIT_ROW)) begin
          note.y <= note.y + 1'b1;
        end else begin
          if (hit) begin
            // Decimal carry into tens
            if (unit_sum >= 5'd10) begin
              score.units <= 4'(unit_sum - 5'd10);
              score.tens  <= (score.tens == 4'd9) ? 4'd0 : score.tens + 4'd1;
            end else begin
              score.units <= unit_sum[3:0];
            end
            if (bonus < 4'(`BONUS_MAX)) begin
              bonus <= {bonus[2:0], 1'b0};
            end
          end else if (miss) begin
            bonus <= 4'd1;
          end
          cur_lane <= spawn_lane;
          note.x   <= lane_left(spawn_lane);
          note.y   <= '0;
        end
      end
    end
  end

  a_units_decimal: assert property (
    @(posedge clk) disable iff (!reset) score.units <= 4'd9
  );

endmodule

`default_nettype wire

// File: logic/note_painter.sv
`timescale 1ns/1ps
`default_nettype none

module note_painter (
  input  wire logic                 clk,
  input  wire logic                 reset,
  input  wire logic                 paint,
  input  wire logic                 ink,
  input  wire game_pkg::note_pos_t  note,
  output logic                      plot,
  output game_pkg::pixel_t          pixel,
  output logic                      block_done
);

  game_pkg::block_step_u count;

  always_ff @(posedge clk) begin
    if (!reset) begin
      count.raw <= '0;
    end else if (paint) begin
      count.raw <= count.raw + 8'd1; // Wraps back to 0 after the last pixel
    end
  end

  assign plot         = paint;
  assign pixel.x      = note.x + {3'b000, count.pos.col};
  assign pixel.y      = note.y + {4'b0000, count.pos.row};
  assign pixel.colour = ink ? 3'd7 : 3'd0; // White draws, black erases
  assign block_done   = paint && (count.raw == 8'hFF);

  // Each draw or erase must start at the block origin
  a_paint_from_origin: assert property (
    @(posedge clk) disable iff (!reset) $rose(paint) |-> (count.raw == '0)
  );

endmodule

`default_nettype wire

// File: logic/note_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

`include "game_defs.svh"

module note_sequencer (
  input  wire logic       clk,
  input  wire logic       reset,
  input  wire logic       start,
  input  wire logic [1:0] speed,
  input  wire logic       block_done,
  output logic            step,
  output logic            paint,
  output logic            ink
);

  game_pkg::seq_state_t     state;
  game_pkg::seq_state_t     next_state;
  logic [`DELAY_W-1:0]      count;
  logic [`DELAY_W-1:0]      delay_sel;

  always_comb begin
    case (speed)
      2'd0:    delay_sel = `DELAY_W'(`DELAY_0);
      2'd1:    delay_sel = `DELAY_W'(`DELAY_1);
      2'd2:    delay_sel = `DELAY_W'(`DELAY_2);
      default: delay_sel = `DELAY_W'(`DELAY_3);
    endcase
  end

  always_comb begin
    next_state = state;
    case (state)
      game_pkg::seq_idle:  if (start) next_state = game_pkg::seq_load;
      game_pkg::seq_load:  next_state = game_pkg::seq_draw;
      game_pkg::seq_draw:  if (block_done) next_state = game_pkg::seq_hold;
      game_pkg::seq_hold:  if (count == '0) next_state = game_pkg::seq_erase;
      game_pkg::seq_erase: if (block_done) next_state = game_pkg::seq_load;
      default:             next_state = game_pkg::seq_idle;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!reset) begin
      state <= game_pkg::seq_idle;
      count <= '0;
    end else begin
      state <= next_state;
      // Hold lasts delay + 1 cycles as the count runs down to zero
      if (state == game_pkg::seq_hold) begin
        count <= count - 1'b1;
      end else begin
        count <= delay_sel;
      end
    end
  end

  assign step  = (state == game_pkg::seq_load);
  assign ink   = (state == game_pkg::seq_draw);
  assign paint = ink || (state == game_pkg::seq_erase);

  a_step_not_paint: assert property (
    @(posedge clk) disable iff (!reset) !(step && paint)
  );

endmodule

`default_nettype wire

// File: logic/rhythm_top.sv
`timescale 1ns/1ps
`default_nettype none

module rhythm_top (
  input  wire logic       clk,
  input  wire logic       reset,
  input  wire logic [7:0] scan_byte,
  input  wire logic       scan_valid,
  input  wire logic       start,
  input  wire logic [1:0] speed,
  output logic            plot,
  output game_pkg::pixel_t pixel,
  output logic [6:0]      hex0,
  output logic [6:0]      hex1
);

  kbd_pkg::key_set_t   keys;
  game_pkg::note_pos_t note;
  game_pkg::score_t    score;
  logic                step;
  logic                paint;
  logic                ink;
  logic                block_done;

  key_tracker i_key_tracker (
    .clk        (clk),
    .reset      (reset),
    .scan_byte  (scan_byte),
    .scan_valid (scan_valid),
    .keys       (keys)
  );

  note_sequencer i_note_sequencer (
    .clk        (clk),
    .reset      (reset),
    .start      (start),
    .speed      (speed),
    .block_done (block_done),
    .step       (step),
    .paint      (paint),
    .ink        (ink)
  );

  note_painter i_note_painter (
    .clk        (clk),
    .reset      (reset),
    .paint      (paint),
    .ink        (ink),
    .note       (note),
    .plot       (plot),
    .pixel      (pixel),
    .block_done (block_done)
  );

  lane_scorer i_lane_scorer (
    .clk   (clk),
    .reset (reset),
    .step  (step),
    .keys  (keys),
    .note  (note),
    .score (score)
  );

  seg_decoder i_seg_units (.digit(score.units), .seg(hex0));
  seg_decoder i_seg_tens  (.digit(score.tens),  .seg(hex1));

endmodule

`default_nettype wire

// File: logic/seg_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module seg_decoder (
  input  wire logic [3:0] digit,
  output logic      [6:0] seg
);

  // Bits run g down to a and a segment lights on 0
  always_comb begin
    case (digit)
      4'd0:    seg = 7'b1000000;
      4'd1:    seg = 7'b1111001;
      4'd2:    seg = 7'b0100100;
      4'd3:    seg = 7'b0110000;
      4'd4:    seg = 7'b0011001;
      4'd5:    seg = 7'b0010010;
      4'd6:    seg = 7'b0000010;
      4'd7:    seg = 7'b1111000;
      4'd8:    seg = 7'b0000000;
      4'd9:    seg = 7'b0010000;
      default: seg = 7'b1111111; // Blank for non-decimal values
    endcase
  end

endmodule

`default_nettype wire
